/* sim.f */
+incdir+include
source/elink_pkg.sv
source/elink_cfg_regs.sv
source/tx_write_fifo.sv
source/tx_link_serializer.sv
source/elink_tx_top.sv
verif/elink_tx_tb.sv

/* Makefile */
# Verilator build and run of the elink transmit path

VERILATOR ?= verilator
TOP       ?= elink_tx_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard include/*.svh source/*.sv verif/*.sv)

.PHONY: help test clean
.DEFAULT_GOAL := help

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* verif/elink_tx_tb.sv */
`timescale 1ns/1ps
`include "elink_config.svh"

module elink_tx_tb
   import elink_pkg::*;
();

   typedef logic [`ELINK_PW-1:0] word_t;

   localparam int          CLK_PERIOD   = 20;
   localparam logic [31:0] SEED         = 32'hcbf9_64d6;
   localparam int          NBYTES       = `ELINK_PW / 8;
   localparam int          NUM_CFG      = 24;
   localparam int          NUM_TRAFFIC  = 40;
   localparam int          NUM_HELD     = 3;    // queued while disabled
   localparam int          NUM_AFTER    = 12;   // sent after the long stall
   localparam int          HOLD_CYCLES  = 40;
   localparam int          STALL_CYCLES = 60;
   localparam int          NUM_PKTS     = NUM_CFG + NUM_TRAFFIC + 2 + NUM_HELD +
                                          `ELINK_FIFO_DEPTH + 2 + NUM_AFTER;
   localparam int          TIMEOUT_CYCLES = 2 * NUM_PKTS * 20 + HOLD_CYCLES +
                                            STALL_CYCLES + 200;

   logic          clk;
   logic          reset;
   logic          txwr_access;
   emesh_packet_t txwr_packet;
   logic          txwr_wait;
   logic [7:0]    tx_data;
   logic          tx_frame;
   logic          tx_wait;
   logic          elink_en;
   logic [15:0]   clk_config;
   logic [11:0]   chipid;

   // reference model state
   logic [31:0] rng_state;
   word_t       exp_q[$];      // forwarded packets in send order
   logic        shadow_en;
   logic [15:0] shadow_clk;
   logic [11:0] shadow_chipid;
   word_t       rx_pkt;        // bytes gathered off the link
   int          rx_count;
   logic        prev_frame;
   logic        prev_en;
   int unsigned wait_pct;      // random tx_wait density
   logic        hold_wait;     // long stall
   string       test_name;

   elink_tx_top elink_tx_top_inst (
      .clk         (clk),
      .reset       (reset),
      .txwr_access (txwr_access),
      .txwr_packet (txwr_packet),
      .txwr_wait   (txwr_wait),
      .tx_data     (tx_data),
      .tx_frame    (tx_frame),
      .tx_wait     (tx_wait),
      .elink_en    (elink_en),
      .clk_config  (clk_config),
      .chipid      (chipid)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the test did not finish", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
   end

   //####################
   // random source
   //####################

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic int unsigned rand_below(input int unsigned n);
      logic [31:0] r;
      r = lcg_next();
      return (r >> 8) % n;   // low lcg bits are weak
   endfunction

   //####################
   // packet builders
   //####################

   function automatic emesh_packet_t random_packet();
      emesh_packet_t p;
      p.srcaddr  = lcg_next();
      p.data     = lcg_next();
      p.dstaddr  = lcg_next();
      p.ctrlmode = 4'(rand_below(16));
      p.datamode = 2'(rand_below(4));
      p.write    = 1'b1;
      p.access   = 1'b1;
      return p;
   endfunction

   // address in own id and config group at word index idx
   function automatic logic [31:0] cfg_addr(input logic [5:0] idx);
      logic [31:0] r;
      r = lcg_next();
      return {`ELINK_ID, r[8:0], `ELINK_CFG_GROUP, idx, 2'b00};
   endfunction

   function automatic emesh_packet_t config_packet(input logic [5:0] idx,
                                                   input logic [31:0] data);
      emesh_packet_t p;
      p         = random_packet();
      p.dstaddr = cfg_addr(idx);
      p.data    = data;
      return p;
   endfunction

   function automatic emesh_packet_t traffic_packet();
      emesh_packet_t p;
      logic [31:0]   r;
      p = random_packet();
      r = lcg_next();
      case (rand_below(4))
         0: p.dstaddr[31:20] = `ELINK_ID ^ (r[11:0] | 12'h001);   // foreign id
         1: begin
            p.dstaddr = cfg_addr(6'(rand_below(64)));   // config read
            p.write   = 1'b0;
         end
         2: p.dstaddr = cfg_addr(6'(3 + rand_below(61)));   // unmapped index
         default: begin
            p.dstaddr[31:20] = `ELINK_ID;
            p.dstaddr[10:8]  = `ELINK_CFG_GROUP ^ 3'(1 + rand_below(7));   // other group
            p.write          = r[31];
         end
      endcase
      return p;
   endfunction

   //####################
   // model and checks
   //####################

   task automatic check(input string label, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("FAIL %s %s expected %0h actual %0h", test_name, label, expected, actual);
         $display("CHECKS FAILED");
         $fatal(1, "mismatch in %s", test_name);
      end
   endtask

   // config writes to indices 0..2 are swallowed
   // everything else goes to the link
   task automatic apply_model(input emesh_packet_t p);
      if (p.write && (p.dstaddr[31:20] == `ELINK_ID) &&
          (p.dstaddr[10:8] == `ELINK_CFG_GROUP) && (p.dstaddr[7:2] <= 6'd2)) begin
         case (p.dstaddr[7:2])
            6'd0:    shadow_en     = ~p.data[0];
            6'd1:    shadow_clk    = p.data[15:0];
            default: shadow_chipid = p.data[11:0];
         endcase
      end else begin
         exp_q.push_back(p);
      end
   endtask

   task automatic collect_byte();
      rx_pkt = {rx_pkt[`ELINK_PW-9:0], tx_data};   // msb byte first
      rx_count++;
      if (rx_count == NBYTES) begin
         rx_count = 0;
         if (exp_q.size() == 0) begin
            $display("packet %0h came out on the link but none was expected", rx_pkt);
            $display("CHECKS FAILED");
            $fatal(1, "unexpected packet");
         end else begin
            check("link packet", exp_q.pop_front(), rx_pkt);
         end
      end
   endtask

   //####################
   // per cycle driver
   //####################

   task automatic run_cycle(input logic want, input emesh_packet_t pkt, output logic sent);
      @(negedge clk);
      // writes from the cycle before must show now
      check("elink_en", word_t'(shadow_en), word_t'(elink_en));
      check("clk_config", word_t'(shadow_clk), word_t'(clk_config));
      check("chipid", word_t'(shadow_chipid), word_t'(chipid));
      if (tx_frame && !prev_frame) begin
         check("frame start needs elink_en", word_t'(1'b1), word_t'(prev_en));
      end
      prev_frame = tx_frame;
      prev_en    = elink_en;
      tx_wait = hold_wait || (rand_below(100) < wait_pct);
      if (tx_frame && !tx_wait) begin
         collect_byte();   // accepted on the coming edge
      end
      sent        = want && !txwr_wait;   // hold off while full
      txwr_access = sent;
      if (want) begin
         txwr_packet = pkt;
      end
      if (sent) begin
         apply_model(pkt);
      end
   endtask

   task automatic idle(input int n);
      logic s;
      repeat (n) run_cycle(1'b0, '0, s);
   endtask

   task automatic send(input emesh_packet_t p);
      logic s;
      s = 1'b0;
      while (!s) run_cycle(1'b1, p, s);
   endtask

   task automatic drain();
      while (exp_q.size() != 0) idle(1);
   endtask

   //####################
   // test sequence
   //####################

   initial begin
      emesh_packet_t pending;
      logic          s;
      rng_state     = SEED;
      reset         = 1'b1;
      txwr_access   = 1'b0;
      txwr_packet   = '0;
      tx_wait       = 1'b0;
      hold_wait     = 1'b0;
      wait_pct      = 0;
      shadow_en     = 1'b1;
      shadow_clk    = `ELINK_CLK_DEFAULT;
      shadow_chipid = `ELINK_CHIPID_DEFAULT;
      rx_pkt        = '0;
      rx_count      = 0;
      prev_frame    = 1'b0;
      prev_en       = 1'b1;
      test_name     = "reset_values";
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check("elink_en", word_t'(1'b1), word_t'(elink_en));
      check("clk_config", word_t'(16'h0573), word_t'(clk_config));
      check("chipid", word_t'(12'h808), word_t'(chipid));
      check("tx_frame", word_t'(1'b0), word_t'(tx_frame));
      check("txwr_wait", word_t'(1'b0), word_t'(txwr_wait));

      test_name = "config_writes";   // any link byte here has no queue entry
      for (int i = 0; i < NUM_CFG; i++) begin
         if (rand_below(2) == 0) begin
            send(config_packet(E_CLK, lcg_next()));
         end else begin
            send(config_packet(E_CHIPID, lcg_next()));
         end
         idle(int'(rand_below(3)));
      end
      idle(2);

      test_name = "forwarded_traffic";
      wait_pct  = 25;
      for (int i = 0; i < NUM_TRAFFIC; i++) begin
         send(traffic_packet());
         idle(int'(rand_below(4)));
      end
      drain();

      test_name = "master_enable";
      wait_pct  = 0;
      send(config_packet(E_RESET, lcg_next() | 32'h1));   // soft reset on
      idle(1);
      for (int i = 0; i < NUM_HELD; i++) begin
         send(traffic_packet());
      end
      idle(HOLD_CYCLES);
      check("packets held while disabled", word_t'(NUM_HELD), word_t'(exp_q.size()));
      check("bytes sent while disabled", '0, word_t'(rx_count));
      send(config_packet(E_RESET, lcg_next() & ~32'h1));
      drain();

      test_name = "back_pressure";
      hold_wait = 1'b1;
      // one packet sits in the serializer and the rest fill the fifo
      for (int i = 0; i < `ELINK_FIFO_DEPTH + 1; i++) begin
         send(traffic_packet());
      end
      pending = traffic_packet();
      repeat (STALL_CYCLES) begin
         run_cycle(1'b1, pending, s);
         check("source held off while full", '0, word_t'(s));
      end
      hold_wait = 1'b0;
      wait_pct  = 40;
      send(pending);
      for (int i = 0; i < NUM_AFTER; i++) begin
         send(traffic_packet());
         idle(int'(rand_below(3)));
      end
      drain();
      idle(20);   // room for stray frames

      if (exp_q.size() != 0 || rx_count != 0) begin
         $display("%0d packets and %0d bytes left over at the end", exp_q.size(), rx_count);
         $display("CHECKS FAILED");
         $fatal(1, "leftover traffic");
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

/* source/elink_tx_top.sv */
`timescale 1ns/1ps

module elink_tx_top
   import elink_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          txwr_access,   // write strobe from mesh
   input  emesh_packet_t txwr_packet,
   output logic          txwr_wait,     // fifo full, hold off
   output logic [7:0]    tx_data,
   output logic          tx_frame,
   input  logic          tx_wait,       // link back-pressure
   output logic          elink_en,
   output logic [15:0]   clk_config,
   output logic [11:0]   chipid
);

   logic          gated_access;   // non-config traffic
   logic          fifo_pop;
   logic          fifo_empty;
   emesh_packet_t head_packet;

   //####################
   // config registers
   //####################

   elink_cfg_regs elink_cfg_regs_inst (
      .clk          (clk),
      .reset        (reset),
      .txwr_access  (txwr_access),
      .txwr_packet  (txwr_packet),
      .gated_access (gated_access),
      .elink_en     (elink_en),
      .clk_config   (clk_config),
      .chipid       (chipid)
   );

   //####################
   // write buffer
   //####################

   tx_write_fifo tx_write_fifo_inst (
      .clk       (clk),
      .reset     (reset),
      .push      (gated_access),
      .wr_packet (txwr_packet),
      .pop       (fifo_pop),
      .rd_packet (head_packet),
      .full      (txwr_wait),   // full is the wait level to the source
      .empty     (fifo_empty)
   );

   //####################
   // link output
   //####################

   tx_link_serializer tx_link_serializer_inst (
      .clk       (clk),
      .reset     (reset),
      .rd_packet (head_packet),
      .empty     (fifo_empty),
      .elink_en  (elink_en),
      .tx_wait   (tx_wait),
      .pop       (fifo_pop),
      .tx_data   (tx_data),
      .tx_frame  (tx_frame)
   );

endmodule

/* source/tx_link_serializer.sv */
`timescale 1ns/1ps
`include "elink_config.svh"

module tx_link_serializer
   import elink_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  emesh_packet_t rd_packet,   // fifo head
   input  logic          empty,
   input  logic          elink_en,    // gates frame start only
   input  logic          tx_wait,     // far side stall
   output logic          pop,
   output logic [7:0]    tx_data,
   output logic          tx_frame     // high on every valid byte
);

   localparam int         NBYTES    = `ELINK_PW / 8;   // 13 for a mesh packet
   localparam logic [3:0] LAST_BYTE = 4'(NBYTES - 1);

   link_state_e          state;
   logic [`ELINK_PW-1:0] shift_reg;   // packet being sent, msb byte on the wire
   logic [3:0]           byte_cnt;    // index of byte on tx_data
   logic                 start;
   logic                 advance;
   logic                 last_byte;

   //####################
   // control
   //####################

   // only start from idle, so there is a gap of at least one cycle between frames
   assign start = (state == LINK_IDLE) && !empty && elink_en;

   assign advance   = (state == LINK_SEND) && !tx_wait;   // byte accepted this cycle
   assign last_byte = (byte_cnt == LAST_BYTE);

   assign pop = start;   // head is latched on the same edge

   //####################
   // FSM and counter
   //####################

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= LINK_IDLE;
         byte_cnt <= '0;
      end else begin
         case (state)
            LINK_IDLE: begin
               if (start) begin
                  state    <= LINK_SEND;
                  byte_cnt <= '0;
               end
            end
            LINK_SEND: begin
               // elink_en ignored here, frame always completes
               if (advance) begin
                  if (last_byte) begin
                     state <= LINK_IDLE;
                  end else begin
                     byte_cnt <= byte_cnt + 4'd1;
                  end
               end
            end
         endcase
      end
   end

   //####################
   // datapath
   //####################

   always_ff @(posedge clk) begin
      if (start) begin
         shift_reg <= rd_packet;                                 // latch head
      end else if (advance) begin
         shift_reg <= {shift_reg[`ELINK_PW-9:0], 8'h00};         // next byte up
      end
   end

   assign tx_data  = shift_reg[`ELINK_PW-1 -: 8];   // held while tx_wait
   assign tx_frame = (state == LINK_SEND);

endmodule

/* source/tx_write_fifo.sv */
`timescale 1ns/1ps
`include "elink_config.svh"

module tx_write_fifo
   import elink_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          push,        // write strobe, never while full
   input  emesh_packet_t wr_packet,
   input  logic          pop,         // read strobe, never while empty
   output emesh_packet_t rd_packet,   // head entry, fall through
   output logic          full,
   output logic          empty
);

   localparam int DEPTH = `ELINK_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   emesh_packet_t mem [DEPTH];   // packet storage

   // extra msb is the wrap bit
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic [AW:0] wr_ptr_nxt;
   logic [AW:0] rd_ptr_nxt;

   //####################
   // pointer arithmetic
   //####################

   assign wr_ptr_nxt = wr_ptr + (AW+1)'(push);
   assign rd_ptr_nxt = rd_ptr + (AW+1)'(pop);

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         wr_ptr <= wr_ptr_nxt;
         rd_ptr <= rd_ptr_nxt;
      end
   end

   //####################
   // storage
   //####################

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr[AW-1:0]] <= wr_packet;
      end
   end

   // head is always visible, pop only moves the pointer
   assign rd_packet = mem[rd_ptr[AW-1:0]];

   //####################
   // status flags
   //####################

   // flags follow the next pointers so they are valid one cycle after a push/pop
   always_ff @(posedge clk) begin
      if (reset) begin
         empty <= 1'b1;
         full  <= 1'b0;
      end else begin
         empty <= (wr_ptr_nxt == rd_ptr_nxt);          // same index, same wrap
         full  <= (wr_ptr_nxt[AW-1:0] == rd_ptr_nxt[AW-1:0]) &&
                  (wr_ptr_nxt[AW] != rd_ptr_nxt[AW]);  // same index, wrap differs
      end
   end

endmodule

/* source/elink_cfg_regs.sv */
`timescale 1ns/1ps
`include "elink_config.svh"

module elink_cfg_regs
   import elink_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          txwr_access,    // incoming write strobe
   input  emesh_packet_t txwr_packet,
   output logic          gated_access,   // forward to tx fifo
   output logic          elink_en,       // master enable
   output logic [15:0]   clk_config,     // pll settings
   output logic [11:0]   chipid
);

   logic        cfg_hit;          // packet lands in our config group
   logic        cfg_write;
   cfg_reg_e    reg_idx;          // word index from address
   logic        reset_write;
   logic        clk_write;
   logic        chipid_write;

   logic        soft_reset_reg;   // 1 holds link disabled
   logic [15:0] clk_reg;
   logic [11:0] chipid_reg;

   //####################
   // address decode
   //####################

   assign cfg_hit = txwr_access &
                    (txwr_packet.dstaddr[31:20] == `ELINK_ID) &
                    (txwr_packet.dstaddr[10:8] == `ELINK_CFG_GROUP);

   assign cfg_write = cfg_hit & txwr_packet.write;   // reads pass through

   // word slots, byte offset dropped
   assign reg_idx = cfg_reg_e'(txwr_packet.dstaddr[`ELINK_RFAW+1:2]);

   assign reset_write  = cfg_write & (reg_idx == E_RESET);
   assign clk_write    = cfg_write & (reg_idx == E_CLK);
   assign chipid_write = cfg_write & (reg_idx == E_CHIPID);

   //####################
   // write filter
   //####################

   // register writes are consumed here
   // anything else in the group still goes to the link
   assign gated_access = txwr_access & ~(reset_write | clk_write | chipid_write);

   //####################
   // soft reset / enable
   //####################

   always_ff @(posedge clk) begin
      if (reset) begin
         soft_reset_reg <= 1'b0;                    // enabled out of reset
      end else if (reset_write) begin
         soft_reset_reg <= txwr_packet.data[0];
      end
   end

   assign elink_en = ~soft_reset_reg;

   //####################
   // clock settings
   //####################

   always_ff @(posedge clk) begin
      if (reset) begin
         clk_reg <= `ELINK_CLK_DEFAULT;
      end else if (clk_write) begin
         clk_reg <= txwr_packet.data[15:0];         // upper data bits ignored
      end
   end

   assign clk_config = clk_reg;

   //####################
   // chip id
   //####################

   always_ff @(posedge clk) begin
      if (reset) begin
         chipid_reg <= `ELINK_CHIPID_DEFAULT;
      end else if (chipid_write) begin
         chipid_reg <= txwr_packet.data[11:0];
      end
   end

   assign chipid = chipid_reg;   // all 12 bits visible

endmodule

/* source/elink_pkg.sv */
`include "elink_config.svh"

package elink_pkg;

   //####################
   // mesh packet layout
   //####################

   // msb first, 104 bits in total
   typedef struct packed {
      logic [31:0] srcaddr;    // return address for reads
      logic [31:0] data;       // write data
      logic [31:0] dstaddr;    // target address
      logic [3:0]  ctrlmode;
      logic [1:0]  datamode;   // byte/half/word/double
      logic        write;      // 1 = write, 0 = read
      logic        access;     // packet valid
   } emesh_packet_t;

   //####################
   // config register map
   //####################

   // word index inside the config group
   typedef enum logic [`ELINK_RFAW-1:0] {
      E_RESET  = 6'd0,   // bit 0 holds link in soft reset
      E_CLK    = 6'd1,   // pll clock settings
      E_CHIPID = 6'd2    // chip id
   } cfg_reg_e;

   //####################
   // serializer FSM
   //####################

   typedef enum logic {
      LINK_IDLE,   // waiting for a buffered packet
      LINK_SEND    // bytes going out on the link
   } link_state_e;

endpackage

/* include/elink_config.svh */
`ifndef ELINK_CONFIG_SVH
`define ELINK_CONFIG_SVH

//####################
// mesh packet
//####################

// full emesh packet width in bits
`define ELINK_PW 104

//####################
// config space decode
//####################

// register index width, taken from dstaddr[7:2]
`define ELINK_RFAW 6

`define ELINK_ID        12'h000   // matched against dstaddr[31:20]
`define ELINK_CFG_GROUP 3'h2      // matched against dstaddr[10:8]

//####################
// buffering and defaults
//####################

`define ELINK_FIFO_DEPTH 4        // power of two only

`define ELINK_CLK_DEFAULT    16'h0573   // every clock enabled, slowest divider
`define ELINK_CHIPID_DEFAULT 12'h808

`endif
